// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int XLEN   = 64;
    localparam int XBYTES = XLEN / 8;
    localparam int OFF_W  = $clog2(XBYTES);  // byte offset inside a doubleword

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LD   = 4'd4,
        MEM_LBU  = 4'd5,
        MEM_LHU  = 4'd6,
        MEM_LWU  = 4'd7,
        MEM_SB   = 4'd8,
        MEM_SH   = 4'd9,
        MEM_SW   = 4'd10,
        MEM_SD   = 4'd11
    } mem_op_e;

    function automatic logic [3:0] op_bytes(input mem_op_e op);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: op_bytes = 4'd1;
            MEM_LH, MEM_LHU, MEM_SH: op_bytes = 4'd2;
            MEM_LW, MEM_LWU, MEM_SW: op_bytes = 4'd4;
            MEM_LD, MEM_SD:          op_bytes = 4'd8;
            default:                 op_bytes = 4'd0;  // MEM_NONE touches nothing
        endcase
    endfunction

    function automatic logic op_is_load(input mem_op_e op);
        op_is_load = op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LD, MEM_LBU, MEM_LHU, MEM_LWU};
    endfunction

    function automatic logic op_is_store(input mem_op_e op);
        op_is_store = op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SD};
    endfunction

endpackage

`default_nettype wire

// ==== src/lsu_cfg_pkg.sv ====
`default_nettype none

package lsu_cfg_pkg;

    localparam int CFG_DW = 32;

    typedef enum logic [1:0] {
        CFG_CTRL      = 2'd0,
        CFG_LOAD_CNT  = 2'd1,
        CFG_STORE_CNT = 2'd2,
        CFG_FAULT_CNT = 2'd3
    } cfg_addr_e;

    // control register layout
    localparam int CTRL_ALLOW_MIS_BIT = 0;

    localparam logic [CFG_DW-1:0] CTRL_RESET = CFG_DW'(1) << CTRL_ALLOW_MIS_BIT;

endpackage

`default_nettype wire

// ==== src/dmem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dmem_if
    import mem_pkg::*;
#(
    parameter int BANK_DEPTH = 256
) ();
    localparam int IDX_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

    logic [IDX_W-1:0]  even_idx;
    logic [IDX_W-1:0]  odd_idx;
    logic [XLEN-1:0]   even_wdata;
    logic [XLEN-1:0]   odd_wdata;
    logic [XBYTES-1:0] even_wmask;
    logic [XBYTES-1:0] odd_wmask;
    logic              rd_en;
    logic [XLEN-1:0]   even_rdata;
    logic [XLEN-1:0]   odd_rdata;

    modport issue (
        output even_idx, odd_idx, even_wdata, odd_wdata, even_wmask, odd_wmask, rd_en
    );

    modport ram (
        input  even_idx, odd_idx, even_wdata, odd_wdata, even_wmask, odd_wmask, rd_en,
        output even_rdata, odd_rdata
    );

endinterface

`default_nettype wire

// ==== src/lsu_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_issue
    import mem_pkg::*;
#(
    parameter int BANK_DEPTH = 256
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid,
    input  logic [XLEN-1:0]  addr,
    input  logic [XLEN-1:0]  store_data,
    input  mem_op_e          op,
    input  logic             allow_misaligned,
    dmem_if.issue            dmem,
    output logic             s1_valid,
    output mem_op_e          s1_op,
    output logic [OFF_W-1:0] s1_offset,
    output logic             s1_swap,
    output logic             s1_fault,
    output logic             ld_evt,
    output logic             st_evt,
    output logic             fault_evt
);
    localparam int IDX_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;
    localparam int MW    = 2 * XBYTES;
    localparam int DW2   = 2 * XLEN;

    logic [OFF_W-1:0]  offset;
    logic [3:0]        nbytes;
    logic              crossing;
    logic              is_load;
    logic              is_store;
    logic              fault_now;
    logic              first_odd;
    logic [XLEN-1:0]   row_full;
    logic [IDX_W-1:0]  row_first;
    logic [IDX_W-1:0]  row_next;
    logic [MW-1:0]     mask_sh;
    logic [DW2-1:0]    data_sh;
    logic [XBYTES-1:0] mask_lo;
    logic [XBYTES-1:0] mask_hi;

    assign offset   = addr[OFF_W-1:0];
    assign nbytes   = op_bytes(op);
    assign crossing = (5'(offset) + 5'(nbytes)) > 5'(XBYTES);
    assign is_load  = valid && op_is_load(op);
    assign is_store = valid && op_is_store(op);

    // blocked only when crossing a doubleword with the control bit clear
    assign fault_now = (is_load || is_store) && crossing && !allow_misaligned;

    // doubleword index is addr >> 3 and its parity picks the bank
    assign first_odd = addr[OFF_W];
    assign row_full  = (addr >> (OFF_W + 1)) % XLEN'(BANK_DEPTH);
    assign row_first = row_full[IDX_W-1:0];
    assign row_next  = (row_first == IDX_W'(BANK_DEPTH - 1)) ? '0 : row_first + 1'b1;

    assign mask_sh = ((MW'(1) << nbytes) - MW'(1)) << offset;
    assign data_sh = {{XLEN{1'b0}}, store_data} << {offset, 3'b000};
    assign mask_lo = (is_store && !fault_now) ? mask_sh[XBYTES-1:0] : '0;
    assign mask_hi = (is_store && !fault_now) ? mask_sh[MW-1:XBYTES] : '0;

    // second doubleword of an odd start wraps into the next even row
    assign dmem.even_idx   = first_odd ? row_next : row_first;
    assign dmem.odd_idx    = row_first;
    assign dmem.even_wdata = first_odd ? data_sh[DW2-1:XLEN] : data_sh[XLEN-1:0];
    assign dmem.odd_wdata  = first_odd ? data_sh[XLEN-1:0] : data_sh[DW2-1:XLEN];
    assign dmem.even_wmask = first_odd ? mask_hi : mask_lo;
    assign dmem.odd_wmask  = first_odd ? mask_lo : mask_hi;
    assign dmem.rd_en      = is_load;

    assign ld_evt    = is_load;
    assign st_evt    = is_store;
    assign fault_evt = fault_now;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_fault <= 1'b0;
        end else begin
            s1_valid <= valid && (op != MEM_NONE);
            s1_fault <= fault_now;
        end
    end

    always_ff @(posedge clk) begin
        s1_op     <= op;
        s1_offset <= offset;
        s1_swap   <= first_odd;  // first doubleword came from the odd bank
    end

    // an idle opcode must neither write nor read a bank
    a_none_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (op == MEM_NONE) |-> (dmem.even_wmask == '0 && dmem.odd_wmask == '0 && !dmem.rd_en))
        else $error("MEM_NONE enabled a bank access");

endmodule

`default_nettype wire

// ==== src/dmem_banked.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_banked
    import mem_pkg::*;
#(
    parameter int BANK_DEPTH = 256
) (
    input  logic clk,
    dmem_if.ram  dmem
);
    localparam int IDX_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

    logic [IDX_W-1:0]  bank_idx   [2];
    logic [XLEN-1:0]   bank_wdata [2];
    logic [XBYTES-1:0] bank_wmask [2];

    // bank 0 even doublewords, bank 1 odd ones
    assign bank_idx[0]   = dmem.even_idx;
    assign bank_idx[1]   = dmem.odd_idx;
    assign bank_wdata[0] = dmem.even_wdata;
    assign bank_wdata[1] = dmem.odd_wdata;
    assign bank_wmask[0] = dmem.even_wmask;
    assign bank_wmask[1] = dmem.odd_wmask;

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [XLEN-1:0] mem [BANK_DEPTH];
        logic [XLEN-1:0] merged;
        logic [XLEN-1:0] rd_q;

        always_comb begin
            merged = mem[bank_idx[b]];
            for (int i = 0; i < XBYTES; i++) begin
                if (bank_wmask[b][i]) begin
                    merged[8*i +: 8] = bank_wdata[b][8*i +: 8];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (|bank_wmask[b]) begin
                mem[bank_idx[b]] <= merged;
            end
            if (dmem.rd_en) begin
                rd_q <= merged;  // write-first on the same row
            end
        end
    end

    assign dmem.even_rdata = g_bank[0].rd_q;
    assign dmem.odd_rdata  = g_bank[1].rd_q;

endmodule

`default_nettype wire

// ==== src/load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_align
    import mem_pkg::*;
(
    input  logic             s1_valid,
    input  mem_op_e          s1_op,
    input  logic [OFF_W-1:0] s1_offset,
    input  logic             s1_swap,
    input  logic             s1_fault,
    input  logic [XLEN-1:0]  even_rdata,
    input  logic [XLEN-1:0]  odd_rdata,
    output logic             valid_out,
    output logic [XLEN-1:0]  load_data,
    output logic             fault
);
    logic [2*XLEN-1:0] pair;
    logic [2*XLEN-1:0] pair_sh;
    logic [XLEN-1:0]   raw;
    logic [XLEN-1:0]   ext;

    // first doubleword in the low half
    assign pair    = s1_swap ? {even_rdata, odd_rdata} : {odd_rdata, even_rdata};
    assign pair_sh = pair >> {s1_offset, 3'b000};
    assign raw     = pair_sh[XLEN-1:0];

    always_comb begin
        case (s1_op)
            MEM_LB:  ext = {{(XLEN-8){raw[7]}}, raw[7:0]};
            MEM_LH:  ext = {{(XLEN-16){raw[15]}}, raw[15:0]};
            MEM_LW:  ext = {{(XLEN-32){raw[31]}}, raw[31:0]};
            MEM_LD:  ext = raw;
            MEM_LBU: ext = {{(XLEN-8){1'b0}}, raw[7:0]};
            MEM_LHU: ext = {{(XLEN-16){1'b0}}, raw[15:0]};
            MEM_LWU: ext = {{(XLEN-32){1'b0}}, raw[31:0]};
            default: ext = '0;
        endcase
    end

    assign valid_out = s1_valid;
    assign fault     = s1_fault;
    assign load_data = (s1_valid && op_is_load(s1_op) && !s1_fault) ? ext : '0;

    // fault and valid are registered separately upstream
    always_comb begin
        a_fault_valid: assert final (!fault || valid_out)
            else $error("fault without valid_out");
    end

endmodule

`default_nettype wire

// ==== src/lsu_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_csr
    import lsu_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cfg_we,
    input  logic [1:0]        cfg_addr,
    input  logic [CFG_DW-1:0] cfg_wdata,
    output logic [CFG_DW-1:0] cfg_rdata,
    input  logic              ld_evt,
    input  logic              st_evt,
    input  logic              fault_evt,
    output logic              allow_misaligned
);
    cfg_addr_e         sel;
    logic [CFG_DW-1:0] load_cnt;
    logic [CFG_DW-1:0] store_cnt;
    logic [CFG_DW-1:0] fault_cnt;

    assign sel = cfg_addr_e'(cfg_addr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            allow_misaligned <= CTRL_RESET[CTRL_ALLOW_MIS_BIT];
            load_cnt         <= '0;
            store_cnt        <= '0;
            fault_cnt        <= '0;
        end else begin
            if (cfg_we && sel == CFG_CTRL) begin
                allow_misaligned <= cfg_wdata[CTRL_ALLOW_MIS_BIT];
            end
            // counters wrap, writes to them are dropped
            load_cnt  <= load_cnt + CFG_DW'(ld_evt);
            store_cnt <= store_cnt + CFG_DW'(st_evt);
            fault_cnt <= fault_cnt + CFG_DW'(fault_evt);
        end
    end

    always_comb begin
        cfg_rdata = '0;
        case (sel)
            CFG_CTRL:      cfg_rdata[CTRL_ALLOW_MIS_BIT] = allow_misaligned;
            CFG_LOAD_CNT:  cfg_rdata = load_cnt;
            CFG_STORE_CNT: cfg_rdata = store_cnt;
            CFG_FAULT_CNT: cfg_rdata = fault_cnt;
            default:       cfg_rdata = '0;
        endcase
    end

    // issue stage must honour the control bit
    a_no_fault_when_allowed: assert property (@(posedge clk) disable iff (!rst_n)
        fault_evt |-> !allow_misaligned)
        else $error("fault raised while misaligned access allowed");

endmodule

`default_nettype wire

// ==== src/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import mem_pkg::*;
#(
    parameter int BANK_DEPTH = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] store_data,
    input  mem_op_e         op,
    output logic            valid_out,
    output logic [XLEN-1:0] load_data,
    output logic            fault,
    input  logic            cfg_we,
    input  logic [1:0]      cfg_addr,
    input  logic [31:0]     cfg_wdata,
    output logic [31:0]     cfg_rdata
);
    logic             allow_misaligned;
    logic             ld_evt;
    logic             st_evt;
    logic             fault_evt;
    logic             s1_valid;
    mem_op_e          s1_op;
    logic [OFF_W-1:0] s1_offset;
    logic             s1_swap;
    logic             s1_fault;

    dmem_if #(.BANK_DEPTH(BANK_DEPTH)) dmem ();

    lsu_issue #(.BANK_DEPTH(BANK_DEPTH)) u_issue (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid            (valid),
        .addr             (addr),
        .store_data       (store_data),
        .op               (op),
        .allow_misaligned (allow_misaligned),
        .dmem             (dmem.issue),
        .s1_valid         (s1_valid),
        .s1_op            (s1_op),
        .s1_offset        (s1_offset),
        .s1_swap          (s1_swap),
        .s1_fault         (s1_fault),
        .ld_evt           (ld_evt),
        .st_evt           (st_evt),
        .fault_evt        (fault_evt)
    );

    dmem_banked #(.BANK_DEPTH(BANK_DEPTH)) u_ram (
        .clk  (clk),
        .dmem (dmem.ram)
    );

    load_align u_align (
        .s1_valid   (s1_valid),
        .s1_op      (s1_op),
        .s1_offset  (s1_offset),
        .s1_swap    (s1_swap),
        .s1_fault   (s1_fault),
        .even_rdata (dmem.even_rdata),
        .odd_rdata  (dmem.odd_rdata),
        .valid_out  (valid_out),
        .load_data  (load_data),
        .fault      (fault)
    );

    lsu_csr u_csr (
        .clk              (clk),
        .rst_n            (rst_n),
        .cfg_we           (cfg_we),
        .cfg_addr         (cfg_addr),
        .cfg_wdata        (cfg_wdata),
        .cfg_rdata        (cfg_rdata),
        .ld_evt           (ld_evt),
        .st_evt           (st_evt),
        .fault_evt        (fault_evt),
        .allow_misaligned (allow_misaligned)
    );

endmodule

`default_nettype wire

// ==== tests/tb_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu
    import mem_pkg::*, lsu_cfg_pkg::*;
();
    localparam int BANK_DEPTH = 64;
    localparam int MEM_BYTES  = 2 * BANK_DEPTH * 8;

    typedef struct packed {
        logic [31:0] due;
        logic        vld;
        logic        flt;
        logic [63:0] data;
    } exp_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        valid;
    logic [63:0] addr;
    logic [63:0] store_data;
    mem_op_e     op;
    logic        valid_out;
    logic [63:0] load_data;
    logic        fault;
    logic        cfg_we;
    logic [1:0]  cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;

    logic [7:0]  mem_model [MEM_BYTES];
    exp_t        exp_q [$];
    logic [31:0] neg_cnt = '0;
    logic        allow_mis = 1'b1;
    int          errors = 0;
    int          checks = 0;
    int          n_ld = 0;
    int          n_st = 0;
    int          n_flt = 0;
    integer      seed = 32'ha8a5;

    always #50 clk = ~clk;

    lsu_top #(.BANK_DEPTH(BANK_DEPTH)) dut (
        .clk(clk), .rst_n(rst_n), .valid(valid), .addr(addr), .store_data(store_data),
        .op(op), .valid_out(valid_out), .load_data(load_data), .fault(fault),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
    );

    function automatic int access_size(input mem_op_e o);
        case (o)
            MEM_LB, MEM_LBU, MEM_SB: return 1;
            MEM_LH, MEM_LHU, MEM_SH: return 2;
            MEM_LW, MEM_LWU, MEM_SW: return 4;
            MEM_LD, MEM_SD:          return 8;
            default:                 return 0;
        endcase
    endfunction

    function automatic logic is_load_op(input mem_op_e o);
        return o inside {MEM_LB, MEM_LH, MEM_LW, MEM_LD, MEM_LBU, MEM_LHU, MEM_LWU};
    endfunction

    function automatic logic is_store_op(input mem_op_e o);
        return o inside {MEM_SB, MEM_SH, MEM_SW, MEM_SD};
    endfunction

    function automatic int byte_index(input logic [63:0] a, input int i);
        return int'((a + 64'(i)) % 64'(MEM_BYTES));  // memory wraps at the top
    endfunction

    // expected {fault, load_data} for a request issued now
    function automatic logic [64:0] ref_access(input mem_op_e o, input logic [63:0] a);
        int          n;
        int          off;
        logic        flt;
        logic [63:0] v;
        n   = access_size(o);
        off = int'(a[2:0]);
        flt = (n != 0) && (off + n > 8) && !allow_mis;
        v   = '0;
        if (is_load_op(o) && !flt) begin
            for (int i = n - 1; i >= 0; i--) begin
                v = {v[55:0], mem_model[byte_index(a, i)]};  // little endian
            end
            case (o)
                MEM_LB:  v = {{56{v[7]}}, v[7:0]};
                MEM_LH:  v = {{48{v[15]}}, v[15:0]};
                MEM_LW:  v = {{32{v[31]}}, v[31:0]};
                default: ;  // upper bytes already zero
            endcase
        end
        return {flt, v};
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic drive(input mem_op_e o, input logic [63:0] a, input logic [63:0] d);
        logic [64:0] r;
        exp_t        e;
        @(posedge clk);
        valid      <= (o != MEM_NONE);
        op         <= o;
        addr       <= a;
        store_data <= d;
        cfg_we     <= 1'b0;
        r      = ref_access(o, a);
        e.due  = neg_cnt + 32'd1;  // result is checked at the second falling edge
        e.vld  = (o != MEM_NONE);
        e.flt  = r[64];
        e.data = r[63:0];
        exp_q.push_back(e);
        if (is_load_op(o)) n_ld++;
        if (is_store_op(o)) n_st++;
        if (r[64]) n_flt++;
        if (is_store_op(o) && !r[64]) begin
            for (int i = 0; i < access_size(o); i++) begin
                mem_model[byte_index(a, i)] = d[8*i +: 8];
            end
        end
    endtask

    task automatic cfg_write(input cfg_addr_e a, input logic [31:0] d);
        drive(MEM_NONE, 64'd0, 64'd0);
        cfg_we    <= 1'b1;
        cfg_addr  <= a;
        cfg_wdata <= d;
        if (a == CFG_CTRL) allow_mis = d[CTRL_ALLOW_MIS_BIT];
    endtask

    task automatic cfg_read(input cfg_addr_e a, input logic [31:0] exp);
        drive(MEM_NONE, 64'd0, 64'd0);
        cfg_addr <= a;
        @(negedge clk);
        check_val("cfg_rdata", 64'(cfg_rdata), 64'(exp));
    endtask

    always @(negedge clk) begin
        if (exp_q.size() > 0 && exp_q[0].due == neg_cnt) begin
            check_val("valid_out", 64'(valid_out), 64'(exp_q[0].vld));
            check_val("load_data", load_data, exp_q[0].data);
            check_val("fault", 64'(fault), 64'(exp_q[0].flt));
            void'(exp_q.pop_front());
        end
        neg_cnt = neg_cnt + 32'd1;
    end

    initial begin
        mem_op_e     o;
        logic [31:0] r;
        logic [63:0] base;
        int          guard;
        rst_n      <= 1'b0;
        valid      <= 1'b1;  // a load held during reset must not reach valid_out
        addr       <= '0;
        store_data <= '0;
        op         <= MEM_LD;
        cfg_we     <= 1'b0;
        cfg_addr   <= '0;
        cfg_wdata  <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        valid <= 1'b0;
        op    <= MEM_NONE;
        @(negedge clk);
        check_val("valid_out", 64'(valid_out), 64'd0);
        check_val("fault", 64'(fault), 64'd0);
        cfg_read(CFG_LOAD_CNT, 32'd0);
        cfg_read(CFG_STORE_CNT, 32'd0);
        cfg_read(CFG_FAULT_CNT, 32'd0);
        cfg_read(CFG_CTRL, 32'd1 << CTRL_ALLOW_MIS_BIT);
        for (int k = 0; k < 2 * BANK_DEPTH; k++) begin  // fill so every word differs
            base = 64'(k * 8);
            drive(MEM_SD, base, {base[31:0] ^ 32'hc3a5_0f1e, ~base[31:0] + 32'h1357});
        end
        // loads 1..7 and stores 8..11 in the opcode encoding
        for (int s = 0; s < 4; s++) begin
            drive(mem_op_e'(4'(8 + s)), 64'h40, 64'h8192_a3b4_c5d6_e7f8);
            for (int l = 0; l < 7; l++) drive(mem_op_e'(4'(1 + l)), 64'h40, 64'd0);
            drive(mem_op_e'(4'(8 + s)), 64'h40, 64'h7e6d_5c4b_3a29_1807);
            for (int l = 0; l < 7; l++) drive(mem_op_e'(4'(1 + l)), 64'h40, 64'd0);
        end
        for (int w = 0; w < 2; w++) begin
            base = (w == 0) ? 64'h88 : 64'(MEM_BYTES - 8);  // odd row then the wrap
            for (int off = 0; off < 8; off++) begin
                for (int s = 0; s < 4; s++) begin
                    r = $random(seed);
                    drive(mem_op_e'(4'(8 + s)), base + 64'(off), {r, ~r});
                    for (int l = 0; l < 7; l++) begin
                        drive(mem_op_e'(4'(1 + l)), base + 64'(off), 64'd0);
                    end
                end
            end
        end
        cfg_write(CFG_CTRL, 32'd0);
        cfg_read(CFG_CTRL, 32'd0);
        drive(MEM_SD, 64'h1f3, 64'hffff_ffff_ffff_ffff);  // blocked
        drive(MEM_SW, 64'h1fe, 64'h0123_4567_89ab_cdef);  // blocked
        drive(MEM_LD, 64'h1f0, 64'd0);
        drive(MEM_LD, 64'h1f8, 64'd0);
        drive(MEM_LD, 64'h200, 64'd0);
        drive(MEM_SW, 64'h1fc, 64'h1234_5678_9abc_def0);
        for (int off = 0; off < 8; off++) drive(MEM_LW, 64'h1f8 + 64'(off), 64'd0);
        cfg_write(CFG_CTRL, 32'd1);
        for (int k = 0; k < 400; k++) begin
            if (k == 200) cfg_write(CFG_CTRL, 32'd0);
            r    = $random(seed);
            o    = mem_op_e'(4'(1 + r[7:0] % 11));
            base = 64'(r[31:8]) % 64'(MEM_BYTES);
            drive(o, base, {$random(seed), $random(seed)});
            if (is_store_op(o) && r[5]) drive(MEM_LD, base, 64'd0);
        end
        cfg_read(CFG_LOAD_CNT, 32'(n_ld));
        cfg_read(CFG_STORE_CNT, 32'(n_st));
        cfg_read(CFG_FAULT_CNT, 32'(n_flt));
        cfg_write(CFG_LOAD_CNT, 32'hdead_beef);
        cfg_write(CFG_STORE_CNT, 32'h0);
        cfg_write(CFG_FAULT_CNT, 32'h1234_5678);
        cfg_read(CFG_LOAD_CNT, 32'(n_ld));
        cfg_read(CFG_STORE_CNT, 32'(n_st));
        cfg_read(CFG_FAULT_CNT, 32'(n_flt));
        cfg_write(CFG_CTRL, 32'hffff_fffe);
        cfg_read(CFG_CTRL, 32'(allow_mis) << CTRL_ALLOW_MIS_BIT);
        cfg_write(CFG_CTRL, 32'h8000_0001);
        cfg_read(CFG_CTRL, 32'(allow_mis) << CTRL_ALLOW_MIS_BIT);
        guard = 0;
        while (exp_q.size() != 0 && guard < 10) begin
            @(negedge clk);
            guard++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timeout: %0d responses were never compared", exp_q.size());
        end
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/mem_pkg.sv
src/lsu_cfg_pkg.sv
src/dmem_if.sv
src/lsu_issue.sv
src/dmem_banked.sv
src/load_align.sv
src/lsu_csr.sv
src/lsu_top.sv
tests/tb_lsu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the testbench with Verilator, pass is decided from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_lsu -f vlog.f -o sim_lsu \
    && ./obj_dir/sim_lsu | tee sim.log \
    || echo "build or simulation did not complete"

grep -q "All tests passed!" sim.log 2>/dev/null && exit 0 || exit 1
